// ==== design/ptw_consts.svh ====
// widths, slot count and APB map of the walker; root entries must be written before level>0 walks
`ifndef PTW_CONSTS_SVH
`define PTW_CONSTS_SVH

// ========================================
// data path widths
// ========================================
`define PTW_VADR_W 32 // virtual address
`define PTW_ASID_W 8 // address space id
`define PTW_PADR_W 32 // physical address
`define PTW_PTE_W 64 // page table entry, bit 0 is valid
`define PTW_PTR_W 16 // base / root pointer, supplies padr 31..16

// ========================================
// miss slots and root table
// ========================================
`define PTW_SLOTS 4 // slot number doubles as memory tag
`define PTW_ROOT_IDX_W 6 // asid[2:0] followed by vadr[31:29]

// ========================================
// APB register map
// ========================================
`define PTW_APB_AW 16
`define PTW_ROOT_LAST 16'h00FC // root entries 0000..00FC, one word apart
`define PTW_REG_FAULT_ADR 16'hFF00 // read clears the fault
`define PTW_REG_FAULT_ASID 16'hFF10
`define PTW_REG_PTBR 16'hFF20

`endif

// ==== design/ptw_pkg.sv ====
// shared walker types; field layouts here fix the APB word formats of PTBR and root entries
`include "ptw_consts.svh"

package ptw_pkg;

	typedef logic [`PTW_VADR_W-1:0] vadr_t; // virtual address from the TLB
	typedef logic [`PTW_ASID_W-1:0] asid_t;
	typedef logic [`PTW_PADR_W-1:0] padr_t; // PTE address on the memory port

	// page table entry as returned by memory
	typedef struct packed {
		logic [`PTW_PTE_W-2:0] info; // frame number and permissions
		logic v; // entry valid
	} pte_t;

	// page table base register, one APB word
	typedef struct packed {
		logic [`PTW_PTR_W-1:0] base; // padr 31..16 of the flat table
		logic [11:0] rsvd; // reads back as written
		logic [3:0] level; // 0 = flat table, else root pointer lookup
	} ptbr_t;

	// one root table entry
	typedef struct packed {
		logic v; // apb word bit 0
		logic [`PTW_PTR_W-1:0] ptr; // apb word bits 31..16
	} root_ptr_t;

	// miss slot index, also the memory tag
	typedef logic [$clog2(`PTW_SLOTS)-1:0] slot_t;

endpackage

// ==== design/ptw_regs.sv ====
// APB slave with zero wait states, no pslverr; unmapped offsets read zero and ignore writes
`timescale 1ns/1ps
`include "ptw_consts.svh"

module ptw_regs (
	input  logic clk,
	input  logic rst,
	// apb slave
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  logic [`PTW_APB_AW-1:0] paddr_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o,
	// root table read port for the walk engine
	input  logic [`PTW_ROOT_IDX_W-1:0] root_idx_i,
	output ptw_pkg::root_ptr_t root_ptr_o,
	output ptw_pkg::ptbr_t ptbr_o,
	// fault capture
	input  logic fault_valid_i,
	input  ptw_pkg::asid_t fault_asid_i,
	input  ptw_pkg::vadr_t fault_vadr_i,
	output logic fault_pending_o,
	output logic fault_o
);

	logic apb_setup; // first cycle of a transfer
	logic apb_rd; // read access phase
	logic apb_wr; // write access phase
	logic root_sel; // address falls in the root table
	logic [`PTW_ROOT_IDX_W-1:0] apb_idx;

	ptw_pkg::root_ptr_t root_mem [2**`PTW_ROOT_IDX_W];
	ptw_pkg::root_ptr_t apb_root_q; // root entry fetched in setup phase
	ptw_pkg::ptbr_t ptbr_q;
	ptw_pkg::vadr_t fault_vadr_q;
	ptw_pkg::asid_t fault_asid_q;
	logic fault_q;

	assign apb_setup = psel_i & ~penable_i;
	assign apb_rd = psel_i & penable_i & ~pwrite_i;
	assign apb_wr = psel_i & penable_i & pwrite_i;
	assign root_sel = paddr_i <= `PTW_ROOT_LAST;
	assign apb_idx = paddr_i[`PTW_ROOT_IDX_W+1:2]; // word index
	assign pready_o = 1'b1; // never stalls

	// ========================================
	// root pointer table, two ports
	// ========================================
	always_ff @(posedge clk) begin
		if (apb_wr && root_sel)
			root_mem[apb_idx] <= ptw_pkg::root_ptr_t'({pwdata_i[0], pwdata_i[31:16]});
		if (apb_setup)
			apb_root_q <= root_mem[apb_idx]; // ready for the access phase
		root_ptr_o <= root_mem[root_idx_i]; // engine sees it next cycle
	end

	// ========================================
	// PTBR and fault registers
	// ========================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptbr_q <= '0;
			fault_q <= 1'b0;
			fault_vadr_q <= '0;
			fault_asid_q <= '0;
		end else begin
			if (apb_wr && paddr_i == `PTW_REG_PTBR)
				ptbr_q <= ptw_pkg::ptbr_t'(pwdata_i);
			if (fault_valid_i) begin
				fault_q <= 1'b1;
				fault_vadr_q <= fault_vadr_i;
				fault_asid_q <= fault_asid_i;
			end else if (apb_rd && paddr_i == `PTW_REG_FAULT_ADR) begin
				fault_q <= 1'b0; // software acknowledged the fault
			end
		end
	end

	// read mux, only driven during a read access phase
	always_comb begin
		prdata_o = '0;
		if (apb_rd) begin
			if (root_sel) begin
				prdata_o = {apb_root_q.ptr, 15'd0, apb_root_q.v};
			end else begin
				case (paddr_i)
					`PTW_REG_FAULT_ADR: prdata_o = fault_vadr_q;
					`PTW_REG_FAULT_ASID: prdata_o = {{(32-`PTW_ASID_W){1'b0}}, fault_asid_q};
					`PTW_REG_PTBR: prdata_o = ptbr_q;
					default: prdata_o = '0;
				endcase
			end
		end
	end

	assign ptbr_o = ptbr_q;
	assign fault_o = fault_q;
	// include the event in flight so a second fault in the next cycle is dropped
	assign fault_pending_o = fault_q | fault_valid_i;

endmodule

// ==== design/ptw_miss_queue.sv ====
// four-entry miss queue; duplicates of any queued miss are accepted and dropped, offers oldest first
`timescale 1ns/1ps
`include "ptw_consts.svh"

module ptw_miss_queue (
	input  logic clk,
	input  logic rst,
	// miss from the TLB
	input  logic miss_valid_i,
	input  ptw_pkg::asid_t miss_asid_i,
	input  ptw_pkg::vadr_t miss_vadr_i,
	output logic miss_ready_o,
	// offer to the walk engine
	output logic issue_valid_o,
	output ptw_pkg::slot_t issue_slot_o,
	output ptw_pkg::asid_t issue_asid_o,
	output ptw_pkg::vadr_t issue_vadr_o,
	input  logic issue_take_i,
	// slot release
	input  logic done_i,
	input  ptw_pkg::slot_t done_slot_i
);

	localparam int N = `PTW_SLOTS;

	logic [N-1:0] valid_q; // slot holds a miss
	logic [N-1:0] out_q; // read already granted
	logic [N-1:0] older_q [N]; // older_q[i][j]: slot i arrived before slot j
	ptw_pkg::asid_t asid_q [N];
	ptw_pkg::vadr_t vadr_q [N];

	logic [N-1:0] pending; // waiting for a read
	logic [N-1:0] dup_hit; // incoming miss already queued
	logic [N-1:0] has_older; // some older slot is also pending
	logic alloc; // store the incoming miss
	ptw_pkg::slot_t free_slot; // lowest free slot

	// ========================================
	// compare and free slot search
	// ========================================
	always_comb begin
		pending = valid_q & ~out_q;
		dup_hit = '0;
		free_slot = '0;
		for (int i = N - 1; i >= 0; i--) begin
			dup_hit[i] = valid_q[i] && asid_q[i] == miss_asid_i && vadr_q[i] == miss_vadr_i;
			if (!valid_q[i])
				free_slot = ptw_pkg::slot_t'(i); // last write is the lowest
		end
	end

	assign miss_ready_o = ~&valid_q; // any slot free
	assign alloc = miss_valid_i & miss_ready_o & ~|dup_hit;

	// oldest pending slot; stays put until taken since new misses are younger
	always_comb begin
		has_older = '0;
		issue_valid_o = 1'b0;
		issue_slot_o = '0;
		for (int i = 0; i < N; i++) begin
			for (int j = 0; j < N; j++)
				has_older[i] = has_older[i] | (pending[j] & older_q[j][i]);
			if (pending[i] && !has_older[i]) begin
				issue_valid_o = 1'b1;
				issue_slot_o = ptw_pkg::slot_t'(i);
			end
		end
	end

	assign issue_asid_o = asid_q[issue_slot_o];
	assign issue_vadr_o = vadr_q[issue_slot_o];

	// ========================================
	// slot state
	// ========================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= '0;
			out_q <= '0;
			for (int i = 0; i < N; i++)
				older_q[i] <= '0;
		end else begin
			if (alloc) begin
				valid_q[free_slot] <= 1'b1;
				out_q[free_slot] <= 1'b0;
				for (int j = 0; j < N; j++) begin
					older_q[free_slot][j] <= 1'b0; // newest is older than nobody
					older_q[j][free_slot] <= (j != int'(free_slot));
				end
			end
			if (issue_take_i)
				out_q[issue_slot_o] <= 1'b1;
			if (done_i) begin
				valid_q[done_slot_i] <= 1'b0;
				out_q[done_slot_i] <= 1'b0;
			end
		end
	end

	// miss payload
	always_ff @(posedge clk) begin
		if (alloc) begin
			asid_q[free_slot] <= miss_asid_i;
			vadr_q[free_slot] <= miss_vadr_i;
		end
	end

endmodule

// ==== design/ptw_walk_engine.sv ====
// one request in flight on the bus, up to four reads outstanding; tags must be echoed unchanged
`timescale 1ns/1ps
`include "ptw_consts.svh"

module ptw_walk_engine (
	input  logic clk,
	input  logic rst,
	// queue offer
	input  logic issue_valid_i,
	input  ptw_pkg::slot_t issue_slot_i,
	input  ptw_pkg::asid_t issue_asid_i,
	input  ptw_pkg::vadr_t issue_vadr_i,
	output logic issue_take_o,
	output logic done_o,
	output ptw_pkg::slot_t done_slot_o,
	// registers
	input  ptw_pkg::ptbr_t ptbr_i,
	output logic [`PTW_ROOT_IDX_W-1:0] root_idx_o,
	input  ptw_pkg::root_ptr_t root_ptr_i,
	input  logic fault_pending_i,
	output logic fault_valid_o,
	output ptw_pkg::asid_t fault_asid_o,
	output ptw_pkg::vadr_t fault_vadr_o,
	// memory read master
	output logic mem_req_o,
	output ptw_pkg::padr_t mem_addr_o,
	output ptw_pkg::slot_t mem_tag_o,
	input  logic mem_gnt_i,
	input  logic mem_rvalid_i,
	input  ptw_pkg::slot_t mem_rtag_i,
	input  ptw_pkg::pte_t mem_rdata_i,
	// TLB update
	output logic tlb_upd_valid_o,
	input  logic tlb_upd_ready_i,
	output ptw_pkg::asid_t tlb_asid_o,
	output ptw_pkg::vadr_t tlb_vadr_o,
	output ptw_pkg::pte_t tlb_pte_o
);

	localparam int N = `PTW_SLOTS;

	typedef enum logic [1:0] {
		S_IDLE, // wait for a pending miss
		S_ROOT, // root pointer arrives this cycle
		S_REQ // request on the bus until granted
	} state_t;

	state_t state_q;
	ptw_pkg::slot_t cur_slot_q; // miss being issued
	ptw_pkg::asid_t cur_asid_q;
	ptw_pkg::vadr_t cur_vadr_q;

	// per-slot transaction buffer, indexed by tag
	ptw_pkg::asid_t buf_asid [N];
	ptw_pkg::vadr_t buf_vadr [N];
	ptw_pkg::pte_t buf_pte [N];
	logic [N-1:0] rdy_q; // response captured, waiting to retire

	logic start; // accept the offered miss
	logic req_load; // raise mem_req_o next cycle
	logic root_fault; // invalid root pointer
	ptw_pkg::padr_t req_adr;
	ptw_pkg::slot_t req_slot;
	logic ret_any;
	logic ret_ok; // retire a slot this cycle
	ptw_pkg::slot_t ret_slot;

	// base, vadr 28..16, 8-byte entries
	function automatic ptw_pkg::padr_t pte_adr(input logic [`PTW_PTR_W-1:0] base,
			input ptw_pkg::vadr_t va);
		return {base, va[28:16], 3'b000};
	endfunction

	assign root_idx_o = {issue_asid_i[2:0], issue_vadr_i[31:29]}; // looked up during the offer
	assign start = state_q == S_IDLE && issue_valid_i && !fault_pending_i;
	assign root_fault = state_q == S_ROOT && !fault_pending_i && !root_ptr_i.v;
	assign req_load = (start && ptbr_i.level == 4'd0) ||
		(state_q == S_ROOT && !fault_pending_i && root_ptr_i.v);
	assign req_adr = (state_q == S_ROOT) ? pte_adr(root_ptr_i.ptr, cur_vadr_q)
		: pte_adr(ptbr_i.base, issue_vadr_i);
	assign req_slot = (state_q == S_ROOT) ? cur_slot_q : issue_slot_i;
	assign issue_take_o = mem_req_o & mem_gnt_i;

	// lowest ready slot
	always_comb begin
		ret_any = 1'b0;
		ret_slot = '0;
		for (int i = N - 1; i >= 0; i--) begin
			if (rdy_q[i]) begin
				ret_any = 1'b1;
				ret_slot = ptw_pkg::slot_t'(i);
			end
		end
	end

	// output stage free, and no root fault using done/fault this cycle
	assign ret_ok = ret_any && (!tlb_upd_valid_o || tlb_upd_ready_i) && !root_fault;

	// ========================================
	// control
	// ========================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= S_IDLE;
			mem_req_o <= 1'b0;
			tlb_upd_valid_o <= 1'b0;
			fault_valid_o <= 1'b0;
			done_o <= 1'b0;
			rdy_q <= '0;
		end else begin
			fault_valid_o <= 1'b0; // single cycle pulses
			done_o <= 1'b0;
			if (req_load)
				mem_req_o <= 1'b1;
			case (state_q)
				S_IDLE: if (start) state_q <= (ptbr_i.level == 4'd0) ? S_REQ : S_ROOT;
				S_ROOT: begin
					if (req_load) begin
						state_q <= S_REQ;
					end else begin
						state_q <= S_IDLE; // pending fault retries later, bad root frees slot
						if (root_fault) begin
							fault_valid_o <= 1'b1;
							done_o <= 1'b1;
						end
					end
				end
				S_REQ: begin
					if (mem_gnt_i) begin
						mem_req_o <= 1'b0;
						state_q <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
			if (mem_rvalid_i)
				rdy_q[mem_rtag_i] <= 1'b1;
			if (tlb_upd_ready_i)
				tlb_upd_valid_o <= 1'b0;
			if (ret_ok) begin
				rdy_q[ret_slot] <= 1'b0;
				done_o <= 1'b1;
				if (buf_pte[ret_slot].v)
					tlb_upd_valid_o <= 1'b1;
				else if (!fault_pending_i)
					fault_valid_o <= 1'b1; // else dropped behind the pending fault
			end
		end
	end

	// ========================================
	// payload
	// ========================================
	always_ff @(posedge clk) begin
		if (start) begin
			cur_slot_q <= issue_slot_i;
			cur_asid_q <= issue_asid_i;
			cur_vadr_q <= issue_vadr_i;
		end
		if (req_load) begin
			mem_addr_o <= req_adr;
			mem_tag_o <= req_slot;
		end
		if (issue_take_o) begin
			buf_asid[cur_slot_q] <= cur_asid_q;
			buf_vadr[cur_slot_q] <= cur_vadr_q;
		end
		if (mem_rvalid_i)
			buf_pte[mem_rtag_i] <= mem_rdata_i;
		if (root_fault) begin
			fault_asid_o <= cur_asid_q;
			fault_vadr_o <= cur_vadr_q;
			done_slot_o <= cur_slot_q;
		end
		if (ret_ok) begin
			done_slot_o <= ret_slot;
			if (buf_pte[ret_slot].v) begin
				tlb_asid_o <= buf_asid[ret_slot];
				tlb_vadr_o <= buf_vadr[ret_slot];
				tlb_pte_o <= buf_pte[ret_slot];
			end else begin
				fault_asid_o <= buf_asid[ret_slot];
				fault_vadr_o <= buf_vadr[ret_slot];
			end
		end
	end

endmodule

// ==== design/ptw_top.sv ====
// page table walker top; memory must return each tag once, fault blocks new walks until cleared
`timescale 1ns/1ps
`include "ptw_consts.svh"

module ptw_top (
	input  logic clk,
	input  logic rst,
	// apb slave
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  logic [`PTW_APB_AW-1:0] paddr_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o,
	// TLB miss
	input  logic miss_valid_i,
	input  ptw_pkg::asid_t miss_asid_i,
	input  ptw_pkg::vadr_t miss_vadr_i,
	output logic miss_ready_o,
	// memory
	output logic mem_req_o,
	output ptw_pkg::padr_t mem_addr_o,
	output ptw_pkg::slot_t mem_tag_o,
	input  logic mem_gnt_i,
	input  logic mem_rvalid_i,
	input  ptw_pkg::slot_t mem_rtag_i,
	input  ptw_pkg::pte_t mem_rdata_i,
	// TLB update
	output logic tlb_upd_valid_o,
	input  logic tlb_upd_ready_i,
	output ptw_pkg::asid_t tlb_asid_o,
	output ptw_pkg::vadr_t tlb_vadr_o,
	output ptw_pkg::pte_t tlb_pte_o,
	output logic fault_o
);

	// queue to engine
	logic issue_valid;
	ptw_pkg::slot_t issue_slot;
	ptw_pkg::asid_t issue_asid;
	ptw_pkg::vadr_t issue_vadr;
	logic issue_take;
	logic done;
	ptw_pkg::slot_t done_slot;
	// engine and regs
	logic [`PTW_ROOT_IDX_W-1:0] root_idx;
	ptw_pkg::root_ptr_t root_ptr;
	ptw_pkg::ptbr_t ptbr;
	logic fault_pending;
	logic fault_valid;
	ptw_pkg::asid_t fault_asid;
	ptw_pkg::vadr_t fault_vadr;

	ptw_regs i_ptw_regs (
		.clk(clk),
		.rst(rst),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.paddr_i(paddr_i),
		.pwdata_i(pwdata_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.root_idx_i(root_idx),
		.root_ptr_o(root_ptr),
		.ptbr_o(ptbr),
		.fault_valid_i(fault_valid),
		.fault_asid_i(fault_asid),
		.fault_vadr_i(fault_vadr),
		.fault_pending_o(fault_pending),
		.fault_o(fault_o)
	);

	ptw_miss_queue i_ptw_miss_queue (
		.clk(clk),
		.rst(rst),
		.miss_valid_i(miss_valid_i),
		.miss_asid_i(miss_asid_i),
		.miss_vadr_i(miss_vadr_i),
		.miss_ready_o(miss_ready_o),
		.issue_valid_o(issue_valid),
		.issue_slot_o(issue_slot),
		.issue_asid_o(issue_asid),
		.issue_vadr_o(issue_vadr),
		.issue_take_i(issue_take),
		.done_i(done),
		.done_slot_i(done_slot)
	);

	ptw_walk_engine i_ptw_walk_engine (
		.clk(clk),
		.rst(rst),
		.issue_valid_i(issue_valid),
		.issue_slot_i(issue_slot),
		.issue_asid_i(issue_asid),
		.issue_vadr_i(issue_vadr),
		.issue_take_o(issue_take),
		.done_o(done),
		.done_slot_o(done_slot),
		.ptbr_i(ptbr),
		.root_idx_o(root_idx),
		.root_ptr_i(root_ptr),
		.fault_pending_i(fault_pending),
		.fault_valid_o(fault_valid),
		.fault_asid_o(fault_asid),
		.fault_vadr_o(fault_vadr),
		.mem_req_o(mem_req_o),
		.mem_addr_o(mem_addr_o),
		.mem_tag_o(mem_tag_o),
		.mem_gnt_i(mem_gnt_i),
		.mem_rvalid_i(mem_rvalid_i),
		.mem_rtag_i(mem_rtag_i),
		.mem_rdata_i(mem_rdata_i),
		.tlb_upd_valid_o(tlb_upd_valid_o),
		.tlb_upd_ready_i(tlb_upd_ready_i),
		.tlb_asid_o(tlb_asid_o),
		.tlb_vadr_o(tlb_vadr_o),
		.tlb_pte_o(tlb_pte_o)
	);

endmodule

// ==== sim/ptw_clkgen.sv ====
// testbench clock of 100 ns period; reset held high for the first five rising edges
`timescale 1ns/1ps

module ptw_clkgen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o; // 100 ns period
	end

	initial begin
		rst_o = 1'b1;
		repeat (5) @(posedge clk_o);
		@(negedge clk_o) rst_o = 1'b0; // release away from the active edge
	end

endmodule

// ==== sim/ptw_checker.sv ====
// handshake rules of the walker ports; bound into every ptw_top instance
`timescale 1ns/1ps

module ptw_checker (
	input logic clk,
	input logic rst,
	input logic mem_req_o,
	input logic mem_gnt_i,
	input ptw_pkg::padr_t mem_addr_o,
	input ptw_pkg::slot_t mem_tag_o,
	input logic tlb_upd_valid_o,
	input logic tlb_upd_ready_i,
	input ptw_pkg::asid_t tlb_asid_o,
	input ptw_pkg::vadr_t tlb_vadr_o,
	input ptw_pkg::pte_t tlb_pte_o,
	input logic fault_o
);

	// request and its payload hold until granted
	req_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_tag_o))
		else $error("memory request changed before grant");

	// update and its payload hold until accepted
	upd_hold: assert property (@(posedge clk) disable iff (rst)
		tlb_upd_valid_o && !tlb_upd_ready_i |=> tlb_upd_valid_o && $stable(tlb_asid_o)
		&& $stable(tlb_vadr_o) && $stable(tlb_pte_o))
		else $error("TLB update changed before ready");

	// no fault left over once reset is released
	fault_rst: assert property (@(posedge clk) $fell(rst) |-> !fault_o)
		else $error("fault_o high after reset");

endmodule

bind ptw_top ptw_checker i_ptw_checker (.*);

// ==== sim/ptw_tb.sv ====
// walker testbench; memory model answers out of order, PTE invalid where addr[15:3] is all ones
`timescale 1ns/1ps
`include "ptw_consts.svh"

module ptw_tb;

	localparam int NUM_TESTS = 5;

	logic clk, rst;
	logic psel, penable, pwrite;
	logic [`PTW_APB_AW-1:0] paddr;
	logic [31:0] pwdata, prdata;
	logic pready;
	logic miss_valid, miss_ready;
	ptw_pkg::asid_t miss_asid;
	ptw_pkg::vadr_t miss_vadr;
	logic mem_req, mem_gnt, mem_rvalid;
	ptw_pkg::padr_t mem_addr;
	ptw_pkg::slot_t mem_tag, mem_rtag;
	ptw_pkg::pte_t mem_rdata;
	logic tlb_valid, tlb_ready, fault;
	ptw_pkg::asid_t tlb_asid;
	ptw_pkg::vadr_t tlb_vadr;
	ptw_pkg::pte_t tlb_pte;

	integer seed = 52022;
	int err_mismatch = 0;
	int err_other = 0;
	logic rand_ready = 1'b0; // random back-pressure on TLB updates

	logic [31:0] ptbr_m = '0; // shadow of PTBR
	logic [31:0] root_m [64]; // shadow of root table
	// expected walks that close on update or fault
	logic [7:0] exp_asid [$];
	logic [31:0] exp_vadr [$];
	bit exp_open [$];
	int open_count = 0;
	// memory model outstanding reads
	logic [31:0] rsp_adr [$];
	logic [1:0] rsp_tag [$];

	ptw_clkgen i_ptw_clkgen (.clk_o(clk), .rst_o(rst));

	ptw_top i_ptw_top (
		.clk(clk), .rst(rst),
		.psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
		.pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
		.miss_valid_i(miss_valid), .miss_asid_i(miss_asid), .miss_vadr_i(miss_vadr),
		.miss_ready_o(miss_ready),
		.mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_tag_o(mem_tag), .mem_gnt_i(mem_gnt),
		.mem_rvalid_i(mem_rvalid), .mem_rtag_i(mem_rtag), .mem_rdata_i(mem_rdata),
		.tlb_upd_valid_o(tlb_valid), .tlb_upd_ready_i(tlb_ready), .tlb_asid_o(tlb_asid),
		.tlb_vadr_o(tlb_vadr), .tlb_pte_o(tlb_pte), .fault_o(fault)
	);

	// ========================================
	// memory contents and reference walk
	// ========================================
	function automatic logic [63:0] mem_pte(input logic [31:0] a);
		return {~a, a[30:0], a[15:3] != 13'h1FFF}; // every address bit shows up
	endfunction

	function automatic void ref_walk(input logic [7:0] asid, input logic [31:0] va,
			output logic [31:0] adr, output logic [63:0] pte, output bit is_fault);
		logic [31:0] w;
		logic [15:0] base;
		base = ptbr_m[31:16];
		is_fault = 1'b0;
		if (ptbr_m[3:0] != 4'd0) begin
			w = root_m[{asid[2:0], va[31:29]}];
			base = w[31:16];
			if (!w[0])
				is_fault = 1'b1; // no memory read at all
		end
		adr = {base, va[28:16], 3'b000};
		pte = mem_pte(adr);
		if (!pte[0])
			is_fault = 1'b1;
	endfunction

	function automatic int find_open(input logic [7:0] asid, input logic [31:0] va);
		for (int i = 0; i < exp_open.size(); i++)
			if (exp_open[i] && exp_asid[i] == asid && exp_vadr[i] == va)
				return i;
		return -1;
	endfunction

	// ========================================
	// memory model, grants and responses
	// ========================================
	always @(negedge clk) begin
		int k;
		logic [31:0] a;
		logic [63:0] p;
		bit f;
		bit hit;
		mem_rvalid <= 1'b0;
		if (!rst) begin
			if (rsp_adr.size() > 0 && $random(seed) % 2 == 0) begin
				k = $unsigned($random(seed)) % rsp_adr.size(); // any order
				mem_rvalid <= 1'b1;
				mem_rtag <= rsp_tag[k];
				mem_rdata <= mem_pte(rsp_adr[k]);
				rsp_adr.delete(k);
				rsp_tag.delete(k);
			end
			mem_gnt = ($random(seed) % 3) == 0;
			if (mem_gnt && mem_req) begin // handshake at the coming edge
				hit = 1'b0;
				for (int i = 0; i < exp_open.size(); i++) begin
					ref_walk(exp_asid[i], exp_vadr[i], a, p, f);
					if (exp_open[i] && a == mem_addr)
						hit = 1'b1;
				end
				assert (hit) else begin
					$display("memory read at unexpected address %h", mem_addr);
					err_other++;
				end
				rsp_adr.push_back(mem_addr);
				rsp_tag.push_back(mem_tag);
			end
		end
	end

	// ========================================
	// TLB update compare
	// ========================================
	always @(negedge clk) begin
		int k;
		logic [31:0] a;
		logic [63:0] p;
		bit f;
		tlb_ready = rand_ready ? ($random(seed) % 2 == 0) : 1'b1;
		if (!rst && tlb_valid && tlb_ready) begin
			k = find_open(tlb_asid, tlb_vadr);
			if (k < 0) begin
				$display("unexpected TLB update asid %h vadr %h", tlb_asid, tlb_vadr);
				err_other++;
			end else begin
				ref_walk(tlb_asid, tlb_vadr, a, p, f);
				assert (!f && tlb_pte == p) else begin
					$display("MISMATCH tlb_update exp %h act %h", p, tlb_pte);
					err_mismatch++;
				end
				exp_open[k] = 1'b0;
				open_count--;
			end
		end
	end

	// ========================================
	// stimulus tasks
	// ========================================
	task automatic apb_write(input logic [15:0] adr, input logic [31:0] data);
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = adr;
		pwdata = data;
		@(negedge clk) penable = 1'b1;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		if (adr == `PTW_REG_PTBR)
			ptbr_m = data;
		if (adr <= `PTW_ROOT_LAST)
			root_m[adr[7:2]] = data;
	endtask

	task automatic apb_read(input logic [15:0] adr, output logic [31:0] data);
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = adr;
		@(negedge clk) penable = 1'b1;
		#10 data = prdata; // settled in the access phase
		assert (pready) else begin
			$display("MISMATCH pready exp 1 act %b", pready);
			err_mismatch++;
		end
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_read(input string name, input logic [15:0] adr,
			input logic [31:0] exp);
		logic [31:0] d;
		apb_read(adr, d);
		assert (d == exp) else begin
			$display("MISMATCH %s exp %h act %h", name, exp, d);
			err_mismatch++;
		end
	endtask

	task automatic send_miss(input logic [7:0] asid, input logic [31:0] va);
		int n;
		n = 0;
		@(negedge clk);
		while (!miss_ready && n < 2000) begin
			@(negedge clk);
			n++;
		end
		if (!miss_ready) begin
			$display("miss_ready stayed low");
			err_other++;
		end
		if (find_open(asid, va) < 0) begin // a pending repeat expects nothing
			exp_asid.push_back(asid);
			exp_vadr.push_back(va);
			exp_open.push_back(1'b1);
			open_count++;
		end
		miss_valid = 1'b1;
		miss_asid = asid;
		miss_vadr = va;
		@(negedge clk) miss_valid = 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (open_count > 0 && n < 3000) begin
			@(negedge clk);
			n++;
		end
		if (open_count > 0) begin
			$display("%0d walks did not complete", open_count);
			err_other++;
		end
		repeat (20) @(negedge clk); // catch late extra updates
	endtask

	// waits for fault_o, reads back the fault registers and clears the fault
	task automatic take_fault(input logic [7:0] asid, input logic [31:0] va);
		int n, k;
		logic [31:0] a;
		logic [63:0] p;
		bit f;
		ref_walk(asid, va, a, p, f);
		n = 0;
		while (!fault && n < 2000) begin
			@(negedge clk);
			n++;
		end
		assert (fault == f) else begin
			$display("MISMATCH fault_o exp %0b act %0b", f, fault);
			err_mismatch++;
		end
		check_read("fault_asid", `PTW_REG_FAULT_ASID, {24'd0, asid});
		check_read("fault_adr", `PTW_REG_FAULT_ADR, va);
		@(negedge clk);
		assert (!fault) else begin
			$display("fault_o not cleared by the address read");
			err_other++;
		end
		k = find_open(asid, va);
		if (k >= 0) begin
			exp_open[k] = 1'b0;
			open_count--;
		end
	endtask

	// ========================================
	// test sequence
	// ========================================
	initial begin
		logic [31:0] va;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		miss_valid = 1'b0;
		miss_asid = '0;
		miss_vadr = '0;
		mem_gnt = 1'b0;
		mem_rvalid = 1'b0;
		mem_rtag = '0;
		mem_rdata = '0;
		tlb_ready = 1'b1;
		for (int i = 0; i < 64; i++)
			root_m[i] = '0;
		@(negedge rst);

		// register read-back
		check_read("fault_adr_rst", `PTW_REG_FAULT_ADR, 32'd0);
		check_read("fault_asid_rst", `PTW_REG_FAULT_ASID, 32'd0);
		apb_write(`PTW_REG_PTBR, 32'h8000_0000);
		check_read("ptbr", `PTW_REG_PTBR, 32'h8000_0000);
		apb_write(16'h0000, 32'h1234_0001);
		apb_write(16'h00A8, 32'h4000_0001); // asid 5 with vadr 31..29 = 2
		apb_write(16'h00AC, 32'h0000_0000); // asid 5 with vadr 31..29 = 3 left invalid
		apb_write(16'h00FC, 32'hBEEF_0001);
		check_read("root_00", 16'h0000, 32'h1234_0001);
		check_read("root_a8", 16'h00A8, 32'h4000_0001);
		check_read("root_fc", 16'h00FC, 32'hBEEF_0001);

		// flat table walks
		send_miss(8'h11, 32'h0003_4000);
		send_miss(8'h22, 32'hE5A1_7000);
		wait_idle();

		// root pointer walks
		apb_write(`PTW_REG_PTBR, 32'h8000_0001);
		send_miss(8'h05, 32'h4123_0000);
		send_miss(8'h3D, 32'h4777_F000);
		send_miss(8'h00, 32'h0ABC_0000);
		wait_idle();

		// invalid root pointer then invalid PTE
		send_miss(8'h05, 32'h6001_0000);
		take_fault(8'h05, 32'h6001_0000);
		apb_write(`PTW_REG_PTBR, 32'h8000_0000);
		send_miss(8'h42, 32'h1FFF_0123);
		take_fault(8'h42, 32'h1FFF_0123);
		wait_idle();

		// several in flight with back-pressure and repeats
		rand_ready = 1'b1;
		for (int r = 0; r < 3; r++) begin
			for (int k = 0; k < 4; k++) begin
				va = $random(seed);
				va[28:16] = {1'b0, 4'(r), 8'(k)}; // unique and never the invalid PTE
				send_miss(8'($random(seed)), va);
				if (k == 0)
					send_miss(exp_asid[exp_asid.size()-1], va); // still pending
			end
			wait_idle();
		end
		rand_ready = 1'b0;

		$display("errors: %0d mismatch, %0d other", err_mismatch, err_other);
		if (err_mismatch + err_other == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// watchdog
	initial begin
		#(NUM_TESTS * 2000 * 100);
		$display("watchdog expired before the tests finished");
		$display("errors: %0d mismatch, %0d other", err_mismatch, err_other);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+design
design/ptw_pkg.sv
design/ptw_regs.sv
design/ptw_miss_queue.sv
design/ptw_walk_engine.sv
design/ptw_top.sv
sim/ptw_clkgen.sv
sim/ptw_checker.sv
sim/ptw_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the walker testbench with Verilator and runs it from the project root
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module ptw_tb -o ptw_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/ptw_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
	echo "no result line in sim.log"
	exit 1
fi
exit 0
